// File: Bender.yml
package:
  name: fizzle_display

sources:
  - rtl/fizzle_pkg.sv
  - rtl/display_timings.sv
  - rtl/bram_sdp.sv
  - rtl/fizzle_fader.sv
  - rtl/fb_line_reader.sv
  - rtl/linebuffer.sv
  - rtl/fizzle_display.sv
  - target: simulation
    files:
      - tb/tb_fizzle_display.sv

// File: fizzle_display.f
rtl/fizzle_pkg.sv
rtl/display_timings.sv
rtl/bram_sdp.sv
rtl/fizzle_fader.sv
rtl/fb_line_reader.sv
rtl/linebuffer.sv
rtl/fizzle_display.sv
tb/tb_fizzle_display.sv

// File: rtl/bram_sdp.sv
////////////////////////////////////////////////////////////////////////////
// simple dual-port block RAM
// one write port, one registered read port, zero at power-up
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module bram_sdp #(
    parameter  int WIDTH = 8,
    parameter  int DEPTH = 256,
    localparam int ADDRW = $clog2(DEPTH)
) (
    input  wire logic             clk_pix,
    input  wire logic             we,
    input  wire logic [ADDRW-1:0] addr_write,
    input  wire logic [WIDTH-1:0] data_in,
    input  wire logic [ADDRW-1:0] addr_read,
    output      logic [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] memory [DEPTH] = '{default: '0};

    always_ff @(posedge clk_pix) begin
        if (we && (addr_write < DEPTH)) begin  // drop writes past the end
            memory[addr_write] <= data_in;
        end
        data_out <= memory[addr_read];  // one cycle latency
    end

endmodule

`default_nettype wire

// File: rtl/display_timings.sv
////////////////////////////////////////////////////////////////////////////
// display timings, 640x480
// screen position counters with registered sync and data enable
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module display_timings
    import fizzle_pkg::*;
(
    input  wire logic   clk_pix,
    input  wire logic   reset,
    output      coord_t sx,     // horizontal position
    output      coord_t sy,     // vertical position
    output      logic   hsync,  // active low
    output      logic   vsync,  // active low
    output      logic   de      // active area
);

    localparam int HS_STA = H_RES + H_FP;       // first hsync column
    localparam int HS_END = HS_STA + H_SYNC - 1;
    localparam int VS_STA = V_RES + V_FP;       // first vsync line
    localparam int VS_END = VS_STA + V_SYNC - 1;

    coord_t sx_next;
    coord_t sy_next;
    logic   line_end;

    // next position, syncs are decoded from it so they stay aligned with sx/sy
    always_comb begin
        line_end = (sx == H_FULL - 1);
        sx_next  = line_end ? '0 : sx + 1'b1;
        if (line_end) begin
            sy_next = (sy == V_FULL - 1) ? '0 : sy + 1'b1;  // frame wrap
        end else begin
            sy_next = sy;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b1;  // (0,0) is visible
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= ~((sx_next >= HS_STA) && (sx_next <= HS_END));
            vsync <= ~((sy_next >= VS_STA) && (sy_next <= VS_END));
            de    <= (sx_next < H_RES) && (sy_next < V_RES);
        end
    end

    sx_in_line: assert property (@(posedge clk_pix) disable iff (reset) sx <= H_FULL - 1)
        else $error("sx past end of line: %0d", sx);

endmodule

`default_nettype wire

// File: rtl/fb_line_reader.sv
////////////////////////////////////////////////////////////////////////////
// framebuffer line reader
// copies one framebuffer line per SCALE lines through the palette
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module fb_line_reader
    import fizzle_pkg::*;
#(
    parameter  int FB_WIDTH  = 160,
    parameter  int FB_HEIGHT = 120,
    parameter  int SCALE     = 4,
    localparam int FB_ADDRW  = $clog2(FB_WIDTH * FB_HEIGHT),
    localparam int LB_ADDRW  = $clog2(FB_WIDTH)
) (
    input  wire logic                clk_pix,
    input  wire logic                reset,
    input  wire coord_t              sx,
    input  wire coord_t              sy,
    output      logic [FB_ADDRW-1:0] fb_addr_read,
    input  wire colr_idx_t           fb_colr,
    input  wire logic                revealed,
    input  wire logic                pal_we,
    input  wire colr_idx_t           pal_idx,
    input  wire rgb_t                pal_colr,
    output      logic                lb_we,
    output      logic [LB_ADDRW-1:0] lb_addr,
    output      rgb_t                lb_colr
);

    // setup, RAM and palette stages run ahead so writes land on sx H_RES..H_FULL-1
    localparam int PIPE_LEAD = 4;

    typedef enum logic [2:0] {
        IDLE,        // wait for last line of frame
        START,       // rewind to framebuffer line 0
        AWAIT_POS,   // wait for copy start column
        START_LINE,  // address setup, line repeat count
        READ_FB,     // one framebuffer pixel per cycle
        LINE_DONE
    } state_t;

    state_t state;
    state_t state_next;

    rgb_t palette [2**$bits(colr_idx_t)];  // 16 entries

    logic [$clog2(FB_HEIGHT)-1:0] fb_line_cnt;
    logic [$clog2(SCALE)-1:0]     line_rpt;   // display lines per fb line
    logic [LB_ADDRW-1:0]          pix_cnt;
    logic                         rd_valid;   // READ_FB delayed for RAM
    logic [LB_ADDRW-1:0]          rd_addr;    // pix_cnt delayed for RAM
    logic                         copy_start;
    logic                         last_line;
    logic                         last_pixel;
    logic                         read_line;

    always_comb begin
        copy_start = (sx == H_RES - PIPE_LEAD);
        last_line  = (fb_line_cnt == FB_HEIGHT - 1);
        last_pixel = (pix_cnt == FB_WIDTH - 1);
        read_line  = (line_rpt == 0);  // first of each SCALE group
    end

    always_comb begin
        case (state)
            IDLE:       state_next = (sy == V_FULL - 1) ? START : IDLE;
            START:      state_next = AWAIT_POS;
            AWAIT_POS:  state_next = copy_start ? START_LINE : AWAIT_POS;
            START_LINE: state_next = read_line ? READ_FB : AWAIT_POS;
            READ_FB:    state_next = last_pixel ? LINE_DONE : READ_FB;
            LINE_DONE:  state_next = last_line ? IDLE : AWAIT_POS;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state        <= IDLE;
            fb_line_cnt  <= '0;
            line_rpt     <= '0;
            pix_cnt      <= '0;
            fb_addr_read <= '0;
            rd_valid     <= 1'b0;
            lb_we        <= 1'b0;
        end else begin
            state    <= state_next;
            rd_valid <= (state == READ_FB);
            lb_we    <= rd_valid;  // two cycles behind the fb address
            case (state)
                START: begin
                    fb_line_cnt  <= '0;
                    line_rpt     <= '0;
                    fb_addr_read <= '0;
                end
                AWAIT_POS: pix_cnt <= '0;
                START_LINE: begin
                    if (line_rpt == SCALE - 1) begin  // next fb line after this one
                        fb_line_cnt <= fb_line_cnt + 1'b1;
                        line_rpt    <= '0;
                    end else begin
                        line_rpt <= line_rpt + 1'b1;
                    end
                end
                READ_FB: begin
                    fb_addr_read <= fb_addr_read + 1'b1;  // ends on next line base
                    pix_cnt      <= pix_cnt + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // palette lookup, black where the pixel is still hidden
    always_ff @(posedge clk_pix) begin
        rd_addr <= pix_cnt;
        lb_addr <= rd_addr;
        lb_colr <= revealed ? palette[fb_colr] : '0;
    end

    always_ff @(posedge clk_pix) begin
        if (pal_we) begin
            palette[pal_idx] <= pal_colr;
        end
    end

    lb_write_in_blank: assert property (@(posedge clk_pix) disable iff (reset)
        lb_we |-> (sx >= H_RES))
        else $error("line buffer written during active video, sx=%0d", sx);

endmodule

`default_nettype wire

// File: rtl/fizzle_display.sv
////////////////////////////////////////////////////////////////////////////
// fizzle display top level
// 160x120 framebuffer scaled to 640x480, revealed by an LFSR fade
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module fizzle_display
    import fizzle_pkg::*;
#(
    parameter  int FB_WIDTH  = 160,
    parameter  int FB_HEIGHT = 120,
    parameter  int SCALE     = 4,
    parameter  int FADE_WAIT = 240,
    parameter  int FADE_RATE = 3000,
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT,
    localparam int FB_ADDRW  = $clog2(FB_PIXELS),
    localparam int LB_ADDRW  = $clog2(FB_WIDTH)
) (
    input  wire logic                clk_pix,
    input  wire logic                reset,
    input  wire logic                fb_we,     // framebuffer load port
    input  wire logic [FB_ADDRW-1:0] fb_addr,
    input  wire colr_idx_t           fb_colr,
    input  wire logic                pal_we,    // palette load port
    input  wire colr_idx_t           pal_idx,
    input  wire rgb_t                pal_colr,
    output      logic                vga_hsync,
    output      logic                vga_vsync,
    output      logic                vga_de,
    output      rgb_t                vga_rgb
);

    coord_t              sx;
    coord_t              sy;
    logic                hsync;
    logic                vsync;
    logic                de;
    logic [FB_ADDRW-1:0] fb_addr_read;
    colr_idx_t           fb_rd_colr;  // index read back for the line copy
    logic                revealed;
    logic                lb_we;
    logic [LB_ADDRW-1:0] lb_addr;
    rgb_t                lb_colr;

    display_timings timings_640x480 (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de
    );

    bram_sdp #(
        .WIDTH($bits(colr_idx_t)),
        .DEPTH(FB_PIXELS)
    ) framebuffer (
        .clk_pix,
        .we(fb_we),
        .addr_write(fb_addr),
        .data_in(fb_colr),
        .addr_read(fb_addr_read),
        .data_out(fb_rd_colr)
    );

    fizzle_fader #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .FADE_WAIT(FADE_WAIT),
        .FADE_RATE(FADE_RATE)
    ) fader (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .fb_addr_read,
        .revealed
    );

    fb_line_reader #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .SCALE(SCALE)
    ) reader (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .fb_addr_read,
        .fb_colr(fb_rd_colr),
        .revealed,
        .pal_we,
        .pal_idx,
        .pal_colr,
        .lb_we,
        .lb_addr,
        .lb_colr
    );

    linebuffer #(
        .FB_WIDTH(FB_WIDTH),
        .SCALE(SCALE)
    ) lb (
        .clk_pix,
        .reset,
        .sx,
        .hsync,
        .vsync,
        .de,
        .lb_we,
        .lb_addr,
        .lb_colr,
        .vga_rgb,
        .vga_hsync,
        .vga_vsync,
        .vga_de
    );

endmodule

`default_nettype wire

// File: rtl/fizzle_fader.sv
////////////////////////////////////////////////////////////////////////////
// fizzle fader
// waits some frames then walks an LFSR over the reveal buffer
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module fizzle_fader
    import fizzle_pkg::*;
#(
    parameter  int FB_WIDTH  = 160,
    parameter  int FB_HEIGHT = 120,
    parameter  int FADE_WAIT = 240,   // frames before the fade
    parameter  int FADE_RATE = 3000,  // pixel clocks per LFSR step
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT,
    localparam int FB_ADDRW  = $clog2(FB_PIXELS)
) (
    input  wire logic                clk_pix,
    input  wire logic                reset,
    input  wire coord_t              sx,
    input  wire coord_t              sy,
    input  wire logic [FB_ADDRW-1:0] fb_addr_read,  // shared with framebuffer
    output      logic                revealed
);

    logic [$clog2(FADE_WAIT+1)-1:0] cnt_wait;  // frames seen so far
    logic [$clog2(FADE_RATE+1)-1:0] cnt_rate;  // step divider
    logic [LFSR_LEN-1:0]            lfsr;
    logic                           fading;
    logic                           fz_we;
    logic [FB_ADDRW-1:0]            fz_addr;

    always_comb begin
        fading  = (cnt_wait == FADE_WAIT);
        fz_we   = fading && (cnt_rate == FADE_RATE - 1);
        // lfsr skips zero, so offset by one to reach address 0
        fz_addr = FB_ADDRW'(lfsr - 1'b1);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            cnt_wait <= '0;
            cnt_rate <= '0;
            lfsr     <= LFSR_LEN'(1);  // seed
        end else begin
            if (!fading && (sy == V_RES) && (sx == 0)) begin  // vblank start
                cnt_wait <= cnt_wait + 1'b1;
            end
            if (fading) begin
                cnt_rate <= (cnt_rate == FADE_RATE - 1) ? '0 : cnt_rate + 1'b1;
            end
            if (fz_we) begin
                // galois step, shift right and fold taps on the output bit
                lfsr <= {1'b0, lfsr[LFSR_LEN-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
            end
        end
    end

    // one bit per framebuffer pixel, set once and never cleared
    bram_sdp #(
        .WIDTH(1),
        .DEPTH(FB_PIXELS)
    ) reveal_buffer (
        .clk_pix,
        .we(fz_we),
        .addr_write(fz_addr),
        .data_in(1'b1),
        .addr_read(fb_addr_read),
        .data_out(revealed)  // lines up with framebuffer data
    );

    lfsr_nonzero: assert property (@(posedge clk_pix) disable iff (reset) lfsr != '0)
        else $error("fade LFSR locked at zero");

endmodule

`default_nettype wire

// File: rtl/fizzle_pkg.sv
////////////////////////////////////////////////////////////////////////////
// fizzle display shared definitions
// 640x480 timing constants, colour types and the fade LFSR polynomial
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package fizzle_pkg;

    typedef logic [9:0] coord_t;     // screen position, x or y
    typedef logic [3:0] colr_idx_t;  // framebuffer palette index
    typedef logic [3:0] chan_t;      // one colour channel

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // horizontal timing in pixels
    localparam int H_RES  = 640;
    localparam int H_FP   = 16;
    localparam int H_SYNC = 96;
    localparam int H_BP   = 48;
    localparam int H_FULL = H_RES + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_RES  = 480;
    localparam int V_FP   = 10;
    localparam int V_SYNC = 2;
    localparam int V_BP   = 33;
    localparam int V_FULL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // fade sequence, 15 bits covers 160x120
    localparam int LFSR_LEN = 15;
    localparam logic [LFSR_LEN-1:0] LFSR_TAPS = 15'b110_0000_0000_0000;  // x^15 + x^14 + 1

endpackage

`default_nettype wire

// File: rtl/linebuffer.sv
////////////////////////////////////////////////////////////////////////////
// line buffer
// one line of colour, read back SCALE times wider, with output blanking
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module linebuffer
    import fizzle_pkg::*;
#(
    parameter  int FB_WIDTH = 160,
    parameter  int SCALE    = 4,
    localparam int LB_ADDRW = $clog2(FB_WIDTH)
) (
    input  wire logic                clk_pix,
    input  wire logic                reset,
    input  wire coord_t              sx,
    input  wire logic                hsync,
    input  wire logic                vsync,
    input  wire logic                de,
    input  wire logic                lb_we,
    input  wire logic [LB_ADDRW-1:0] lb_addr,
    input  wire rgb_t                lb_colr,
    output      rgb_t                vga_rgb,
    output      logic                vga_hsync,
    output      logic                vga_vsync,
    output      logic                vga_de
);

    rgb_t                     lb_mem [FB_WIDTH] = '{default: '0};  // black until filled
    logic [LB_ADDRW-1:0]      rd_addr;
    logic [$clog2(SCALE)-1:0] pix_rpt;  // column within a scaled pixel

    always_ff @(posedge clk_pix) begin
        if (lb_we) begin
            lb_mem[lb_addr] <= lb_colr;
        end
    end

    // rd_addr = sx/SCALE, loaded on the last column so it is 0 at sx 0
    always_ff @(posedge clk_pix) begin
        if (reset || (sx == H_FULL - 1)) begin
            rd_addr <= '0;
            pix_rpt <= '0;
        end else if (pix_rpt == SCALE - 1) begin
            pix_rpt <= '0;
            if (rd_addr != FB_WIDTH - 1) begin  // hold at line end
                rd_addr <= rd_addr + 1'b1;
            end
        end else begin
            pix_rpt <= pix_rpt + 1'b1;
        end
    end

    // pixel and syncs leave together, one cycle after the timings
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_rgb   <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
        end else begin
            vga_rgb   <= de ? lb_mem[rd_addr] : '0;
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            vga_de    <= de;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_fizzle_display.sv
////////////////////////////////////////////////////////////////////////////
// fizzle display testbench
// loads random memories, follows the output raster, checks sync and fade
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_fizzle_display
    import fizzle_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int FB_WIDTH   = 160;
    localparam int FB_HEIGHT  = 120;
    localparam int SCALE      = 4;
    localparam int FADE_WAIT  = 2;
    localparam int FADE_RATE  = 2;
    localparam int FB_PIXELS  = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW   = $clog2(FB_PIXELS);
    localparam int LAST_FRAME = 4;               // fade long finished by now
    localparam int NUM_FRAMES = LAST_FRAME + 1;
    localparam longint WATCHDOG = (6 * H_FULL * V_FULL + 100 * H_FULL) * CLK_PERIOD;

    // test slots
    localparam int T_SYNC    = 0;
    localparam int T_BLANK   = 1;
    localparam int T_BEFORE  = 2;
    localparam int T_PARTIAL = 3;
    localparam int T_FULL    = 4;

    logic                clk_pix;
    logic                reset;
    logic                fb_we;
    logic [FB_ADDRW-1:0] fb_addr;
    colr_idx_t           fb_colr;
    logic                pal_we;
    colr_idx_t           pal_idx;
    rgb_t                pal_colr;
    logic                vga_hsync;
    logic                vga_vsync;
    logic                vga_de;
    rgb_t                vga_rgb;

    rgb_t        pal_model [16];         // copies of what was loaded
    colr_idx_t   fb_model [FB_PIXELS];
    logic [15:0] rng_state = 16'd24;     // lfsr seed
    rgb_t        exp_rgb;                // model colour at (px, py)

    int px = 0;          // output raster position
    int py = 0;
    int frame_cnt = 0;
    int hs_low = 0;      // cycles hsync has been low
    int hs_gap = 0;      // cycles since last hsync fall
    int hs_falls = 0;
    int vs_low = 0;
    logic hs_prev = 1'b1;
    logic vs_prev = 1'b1;
    logic de_prev = 1'b0;
    int hits [5] = '{default: 0};
    int errs [5] = '{default: 0};
    int tests_run = 0;
    int tests_failed = 0;

    fizzle_display #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .SCALE(SCALE),
        .FADE_WAIT(FADE_WAIT),
        .FADE_RATE(FADE_RATE)
    ) UUT (
        .clk_pix,
        .reset,
        .fb_we,
        .fb_addr,
        .fb_colr,
        .pal_we,
        .pal_idx,
        .pal_colr,
        .vga_hsync,
        .vga_vsync,
        .vga_de,
        .vga_rgb
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    // galois step, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits      = {bits[14:0], rng_state[0]};  // one step per bit
            rng_state = lfsr_next(rng_state);
        end
    endtask

    task automatic load_memories();
        logic [15:0] r;
        for (int i = 0; i < 16; i++) begin
            take_bits(12, r);
            @(posedge clk_pix);
            pal_we       <= 1'b1;
            pal_idx      <= colr_idx_t'(i);
            pal_colr     <= rgb_t'(r[11:0]);
            pal_model[i] = rgb_t'(r[11:0]);
        end
        for (int a = 0; a < FB_PIXELS; a++) begin
            take_bits(4, r);
            @(posedge clk_pix);
            pal_we      <= 1'b0;
            fb_we       <= 1'b1;
            fb_addr     <= FB_ADDRW'(a);
            fb_colr     <= r[3:0];
            fb_model[a] = r[3:0];
        end
        @(posedge clk_pix);
        fb_we <= 1'b0;
    endtask

    task automatic report_test(input string name, input int t);
        tests_run++;
        if (hits[t] == 0) begin
            tests_failed++;
            $display("test %s failed: its checks were never reached", name);
        end else begin
            if (errs[t] != 0) tests_failed++;
            $display("test %s: %0d checks, %0d errors", name, hits[t], errs[t]);
        end
    endtask

    // pixel (x/SCALE, y/SCALE) through the palette copy
    always_comb begin
        exp_rgb = '0;
        if ((px < H_RES) && (py < V_RES)) begin
            exp_rgb = pal_model[fb_model[(py / SCALE) * FB_WIDTH + px / SCALE]];
        end
    end

    // raster follower, counters describe the pixel now on vga_rgb
    always @(posedge clk_pix) begin
        if (!reset) begin
            px <= vga_de ? px + 1 : 0;
            if (de_prev && !vga_de) py <= py + 1;  // end of active line
            if (vs_prev && !vga_vsync) begin       // new frame
                py        <= 0;
                frame_cnt <= frame_cnt + 1;
            end
            hs_low <= vga_hsync ? 0 : hs_low + 1;
            vs_low <= vga_vsync ? 0 : vs_low + 1;
            if (hs_prev && !vga_hsync) begin
                hs_gap   <= 1;
                hs_falls <= hs_falls + 1;
            end else begin
                hs_gap <= hs_gap + 1;
            end
            if (vga_hsync != hs_prev || (vga_vsync && !vs_prev)) hits[T_SYNC] <= hits[T_SYNC] + 1;
            if (!vga_de) hits[T_BLANK] <= hits[T_BLANK] + 1;
            else if (frame_cnt < FADE_WAIT) hits[T_BEFORE] <= hits[T_BEFORE] + 1;
            else if (frame_cnt < LAST_FRAME) hits[T_PARTIAL] <= hits[T_PARTIAL] + 1;
            else if (frame_cnt == LAST_FRAME) hits[T_FULL] <= hits[T_FULL] + 1;
            hs_prev <= vga_hsync;
            vs_prev <= vga_vsync;
            de_prev <= vga_de;
        end
    end

    hsync_width: assert property (@(posedge clk_pix) disable iff (reset)
        $rose(vga_hsync) |-> hs_low == H_SYNC)
        else begin
            errs[T_SYNC]++;
            $display("Error: sync_geometry hsync width expected %0d actual %0d",
                H_SYNC, $sampled(hs_low));
        end

    hsync_period: assert property (@(posedge clk_pix) disable iff (reset)
        $fell(vga_hsync) && (hs_falls > 0) |-> hs_gap == H_FULL)
        else begin
            errs[T_SYNC]++;
            $display("Error: sync_geometry hsync period expected %0d actual %0d",
                H_FULL, $sampled(hs_gap));
        end

    vsync_width: assert property (@(posedge clk_pix) disable iff (reset)
        $rose(vga_vsync) |-> vs_low == V_SYNC * H_FULL)
        else begin
            errs[T_SYNC]++;
            $display("Error: sync_geometry vsync cycles expected %0d actual %0d",
                V_SYNC * H_FULL, $sampled(vs_low));
        end

    // active pixels per line, counted up to the de fall
    de_width: assert property (@(posedge clk_pix) disable iff (reset)
        $fell(vga_de) |-> px == H_RES)
        else begin
            errs[T_SYNC]++;
            $display("Error: sync_geometry active width expected %0d actual %0d",
                H_RES, $sampled(px));
        end

    // active lines seen before vsync
    de_lines: assert property (@(posedge clk_pix) disable iff (reset)
        $fell(vga_vsync) |-> py == V_RES)
        else begin
            errs[T_SYNC]++;
            $display("Error: sync_geometry active lines expected %0d actual %0d",
                V_RES, $sampled(py));
        end

    blank_black: assert property (@(posedge clk_pix) disable iff (reset)
        !vga_de |-> vga_rgb == '0)
        else begin
            errs[T_BLANK]++;
            $display("Error: blanking expected 000 actual %h", $sampled(vga_rgb));
        end

    before_fade_black: assert property (@(posedge clk_pix) disable iff (reset)
        vga_de && (frame_cnt < FADE_WAIT) |-> vga_rgb == '0)
        else begin
            errs[T_BEFORE]++;
            $display("Error: before_fade at (%0d,%0d) expected 000 actual %h",
                $sampled(px), $sampled(py), $sampled(vga_rgb));
        end

    partial_reveal: assert property (@(posedge clk_pix) disable iff (reset)
        vga_de && (frame_cnt >= FADE_WAIT) && (frame_cnt < LAST_FRAME)
        |-> (vga_rgb == '0) || (vga_rgb == exp_rgb))
        else begin
            errs[T_PARTIAL]++;
            $display("Error: partial_reveal at (%0d,%0d) expected %h or 000 actual %h",
                $sampled(px), $sampled(py), $sampled(exp_rgb), $sampled(vga_rgb));
        end

    full_reveal: assert property (@(posedge clk_pix) disable iff (reset)
        vga_de && (frame_cnt == LAST_FRAME) |-> vga_rgb == exp_rgb)
        else begin
            errs[T_FULL]++;
            $display("Error: full_reveal at (%0d,%0d) expected %h actual %h",
                $sampled(px), $sampled(py), $sampled(exp_rgb), $sampled(vga_rgb));
        end

    initial begin
        #(WATCHDOG);
        $display("timeout: the display did not complete %0d frames in time", NUM_FRAMES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        fb_we    = 1'b0;
        fb_addr  = '0;
        fb_colr  = '0;
        pal_we   = 1'b0;
        pal_idx  = '0;
        pal_colr = '0;
        repeat (10) @(posedge clk_pix);
        reset <= 1'b0;
        load_memories();  // finishes well inside frame 0
        wait (frame_cnt == FADE_WAIT);
        @(posedge clk_pix);
        report_test("before_fade", T_BEFORE);
        wait (frame_cnt == LAST_FRAME);
        @(posedge clk_pix);
        report_test("partial_reveal", T_PARTIAL);
        wait (frame_cnt == NUM_FRAMES);  // last frame active area done
        repeat (2) @(posedge clk_pix);
        report_test("full_reveal", T_FULL);
        report_test("sync_geometry", T_SYNC);
        report_test("blanking", T_BLANK);
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
